// ==== hdl/img_proc_pkg.sv ====
`default_nettype none

package img_proc_pkg;

	localparam int IMG_DIM   = 64;          // Image side in pixels
	localparam int HALF_ROWS = IMG_DIM / 2; // Row pairs swapped by the mirror
	localparam int COORD_W   = 6;           // Row or column index width
	localparam int CHAN_W    = 8;           // One colour channel
	localparam int PIX_W     = 3 * CHAN_W;  // R 23:16, G 15:8, B 7:0

	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [CHAN_W-1:0]  chan_t;
	typedef logic [PIX_W-1:0]   pixel_t;

	// Top level pass sequence
	typedef enum logic [1:0] {
		PH_MIRROR = 2'd0, // Swap rows r and 63-r
		PH_GAP    = 2'd1, // One idle cycle, counter back to origin
		PH_GRAY   = 2'd2, // Max/min midpoint into G
		PH_DONE   = 2'd3  // Parked, no more writes
	} phase_e;

	// Mirror sequence for one pixel pair
	typedef enum logic [1:0] {
		MS_READ_TOP  = 2'd0, // Latch pixel at (r, c)
		MS_READ_BOT  = 2'd1, // Latch pixel at (63-r, c)
		MS_WRITE_BOT = 2'd2, // Old top goes down
		MS_WRITE_TOP = 2'd3  // Old bottom goes up, counter steps
	} mir_step_e;

	// Grayscale sequence for one pixel
	typedef enum logic {
		GS_MEASURE = 1'b0, // Register max and min of R,G,B
		GS_WRITE   = 1'b1  // Write the midpoint in G
	} gray_step_e;

endpackage

`default_nettype wire

// ==== hdl/scan_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module scan_counter (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                clear,  // Back to (0,0)
	input  logic                step,   // Advance one pixel
	input  logic                half,   // Stop at the middle row instead of the bottom
	output img_proc_pkg::coord_t row,
	output img_proc_pkg::coord_t col,
	output logic                last    // Final position of the selected region
);
	import img_proc_pkg::*;

	coord_t row_end; // Last row of the region

	assign row_end = half ? coord_t'(HALF_ROWS - 1) : coord_t'(IMG_DIM - 1);

	// Raster walk, left to right then top to bottom
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			row <= '0;
			col <= '0;
		end else if (clear) begin // Clear wins over step
			row <= '0;
			col <= '0;
		end else if (step) begin
			if (col == coord_t'(IMG_DIM - 1)) begin // Wrap into next line
				col <= '0;
				row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	assign last = (row == row_end) && (col == coord_t'(IMG_DIM - 1));

endmodule

`default_nettype wire

// ==== hdl/mirror_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module mirror_engine (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 enable,   // Mirror phase active
	input  img_proc_pkg::coord_t scan_row, // Top row of the current pair
	input  img_proc_pkg::coord_t scan_col,
	input  logic                 last,     // Pair (31,63) reached
	input  img_proc_pkg::pixel_t in_pix,   // Combinational memory read
	output img_proc_pkg::coord_t row,
	output img_proc_pkg::coord_t col,
	output logic                 we,
	output img_proc_pkg::pixel_t pix,
	output logic                 step,     // Move the counter to the next pair
	output logic                 finish    // Last pair written
);
	import img_proc_pkg::*;

	mir_step_e state;
	pixel_t    top_hold; // Pixel read at (r, c)
	pixel_t    bot_hold; // Pixel read at (63-r, c)
	coord_t    mirror_row;
	logic      bot_side;

	// Four steps per pair, held while the phase is elsewhere
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= MS_READ_TOP;
		end else if (enable) begin
			case (state)
				MS_READ_TOP:  state <= MS_READ_BOT;
				MS_READ_BOT:  state <= MS_WRITE_BOT;
				MS_WRITE_BOT: state <= MS_WRITE_TOP;
				default:      state <= MS_READ_TOP;
			endcase
		end
	end

	// Pixel holding registers
	always_ff @(posedge clk) begin
		if (enable && state == MS_READ_TOP) top_hold <= in_pix;
		if (enable && state == MS_READ_BOT) bot_hold <= in_pix;
	end

	assign mirror_row = coord_t'(IMG_DIM - 1) - scan_row; // Row symmetric to the top one
	assign bot_side   = (state == MS_READ_BOT) || (state == MS_WRITE_BOT);

	assign row    = bot_side ? mirror_row : scan_row;
	assign col    = scan_col; // Same column on both sides
	assign we     = enable && (state == MS_WRITE_BOT || state == MS_WRITE_TOP);
	assign pix    = (state == MS_WRITE_BOT) ? top_hold : bot_hold; // Swapped contents
	assign step   = enable && (state == MS_WRITE_TOP);
	assign finish = step && last;

endmodule

`default_nettype wire

// ==== hdl/gray_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module gray_engine (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 enable,   // Grayscale phase active
	input  img_proc_pkg::coord_t scan_row,
	input  img_proc_pkg::coord_t scan_col,
	input  logic                 last,     // Pixel (63,63) reached
	input  img_proc_pkg::pixel_t in_pix,
	output img_proc_pkg::coord_t row,
	output img_proc_pkg::coord_t col,
	output logic                 we,
	output img_proc_pkg::pixel_t pix,
	output logic                 step,
	output logic                 finish
);
	import img_proc_pkg::*;

	gray_step_e        state;
	chan_t             red, green, blue;
	chan_t             hi, lo;          // Max and min of the live pixel
	chan_t             max_q, min_q;    // Registered in GS_MEASURE
	logic [CHAN_W:0]   mid_sum;         // 9 bits, no overflow

	assign red   = in_pix[2*CHAN_W +: CHAN_W];
	assign green = in_pix[CHAN_W +: CHAN_W];
	assign blue  = in_pix[0 +: CHAN_W];

	always_comb begin
		hi = red;
		lo = red;
		if (green > hi) hi = green;
		if (green < lo) lo = green;
		if (blue > hi)  hi = blue;
		if (blue < lo)  lo = blue;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) state <= GS_MEASURE;
		else if (enable) state <= (state == GS_MEASURE) ? GS_WRITE : GS_MEASURE;
	end

	always_ff @(posedge clk) begin
		if (enable && state == GS_MEASURE) begin
			max_q <= hi;
			min_q <= lo;
		end
	end

	assign mid_sum = {1'b0, max_q} + {1'b0, min_q};

	assign row    = scan_row; // Written in place
	assign col    = scan_col;
	assign we     = enable && (state == GS_WRITE);
	assign pix    = {{CHAN_W{1'b0}}, mid_sum[CHAN_W:1], {CHAN_W{1'b0}}}; // Floor of the mean in G
	assign step   = we;
	assign finish = step && last;

endmodule

`default_nettype wire

// ==== hdl/img_proc_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module img_proc_ctrl (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 mir_finish,
	input  logic                 gray_finish,
	input  img_proc_pkg::coord_t mir_row,
	input  img_proc_pkg::coord_t mir_col,
	input  img_proc_pkg::coord_t gray_row,
	input  img_proc_pkg::coord_t gray_col,
	input  logic                 mir_we,
	input  logic                 gray_we,
	input  img_proc_pkg::pixel_t mir_pix,
	input  img_proc_pkg::pixel_t gray_pix,
	input  logic                 mir_step,
	input  logic                 gray_step,
	output logic                 mir_enable,
	output logic                 gray_enable,
	output logic                 scan_clear,  // Counter to origin between passes
	output logic                 scan_step,
	output logic                 scan_half,   // Mirror walks the upper half only
	output img_proc_pkg::coord_t row,
	output img_proc_pkg::coord_t col,
	output logic                 we,
	output img_proc_pkg::pixel_t pix,
	output logic                 mirror_done, // Sticky
	output logic                 gray_done    // Sticky
);
	import img_proc_pkg::*;

	phase_e phase;

	// Phase sequencer and done flags, mirror starts straight out of reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase       <= PH_MIRROR;
			mirror_done <= 1'b0;
			gray_done   <= 1'b0;
		end else begin
			case (phase)
				PH_MIRROR: if (mir_finish) begin
					phase       <= PH_GAP;
					mirror_done <= 1'b1;
				end
				PH_GAP:    phase <= PH_GRAY; // Single idle cycle
				PH_GRAY:   if (gray_finish) begin
					phase     <= PH_DONE;
					gray_done <= 1'b1;
				end
				default:   phase <= PH_DONE; // Parked
			endcase
		end
	end

	assign mir_enable  = (phase == PH_MIRROR);
	assign gray_enable = (phase == PH_GRAY);
	assign scan_clear  = (phase == PH_GAP);
	assign scan_half   = mir_enable;
	assign scan_step   = (mir_enable && mir_step) || (gray_enable && gray_step);

	// Memory port mux, gray side also owns the port once parked
	assign row = mir_enable ? mir_row : gray_row;
	assign col = mir_enable ? mir_col : gray_col;
	assign pix = mir_enable ? mir_pix : gray_pix;
	assign we  = (mir_enable && mir_we) || (gray_enable && gray_we); // Low in gap and done

endmodule

`default_nettype wire

// ==== hdl/img_proc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module img_proc_top (
	input  logic                 clk,
	input  logic                 arst_n,
	input  img_proc_pkg::pixel_t in_pix,      // Combinational read at (row, col)
	output img_proc_pkg::coord_t row,
	output img_proc_pkg::coord_t col,
	output logic                 we,          // Store pix at (row, col) on this edge
	output img_proc_pkg::pixel_t pix,
	output logic                 mirror_done,
	output logic                 gray_done
);
	import img_proc_pkg::*;

	coord_t scan_row, scan_col;
	logic   scan_last, scan_clear, scan_step, scan_half;
	logic   mir_enable, gray_enable;
	coord_t mir_row, mir_col, gray_row, gray_col;
	logic   mir_we, gray_we, mir_step, gray_step, mir_finish, gray_finish;
	pixel_t mir_pix, gray_pix;

	scan_counter scan_counter_i (
		.clk(clk), .arst_n(arst_n), .clear(scan_clear), .step(scan_step), .half(scan_half),
		.row(scan_row), .col(scan_col), .last(scan_last)
	);

	mirror_engine mirror_engine_i (
		.clk(clk), .arst_n(arst_n), .enable(mir_enable),
		.scan_row(scan_row), .scan_col(scan_col), .last(scan_last), .in_pix(in_pix),
		.row(mir_row), .col(mir_col), .we(mir_we), .pix(mir_pix),
		.step(mir_step), .finish(mir_finish)
	);

	gray_engine gray_engine_i (
		.clk(clk), .arst_n(arst_n), .enable(gray_enable),
		.scan_row(scan_row), .scan_col(scan_col), .last(scan_last), .in_pix(in_pix),
		.row(gray_row), .col(gray_col), .we(gray_we), .pix(gray_pix),
		.step(gray_step), .finish(gray_finish)
	);

	img_proc_ctrl img_proc_ctrl_i (
		.clk(clk), .arst_n(arst_n), .mir_finish(mir_finish), .gray_finish(gray_finish),
		.mir_row(mir_row), .mir_col(mir_col), .gray_row(gray_row), .gray_col(gray_col),
		.mir_we(mir_we), .gray_we(gray_we), .mir_pix(mir_pix), .gray_pix(gray_pix),
		.mir_step(mir_step), .gray_step(gray_step),
		.mir_enable(mir_enable), .gray_enable(gray_enable),
		.scan_clear(scan_clear), .scan_step(scan_step), .scan_half(scan_half),
		.row(row), .col(col), .we(we), .pix(pix),
		.mirror_done(mirror_done), .gray_done(gray_done)
	);

endmodule

`default_nettype wire

// ==== verif/img_proc_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module img_proc_props (
	input logic clk,
	input logic arst_n,
	input logic we,
	input logic mirror_done,
	input logic gray_done
);

	// Gap cycle and parked phase follow the two finish points
	we_low_after_done: assert property (@(posedge clk) disable iff (!arst_n)
		($rose(mirror_done) || $rose(gray_done)) |-> !we)
		else $error("write strobe in the cycle after a done flag rose");

	// Grayscale pass only runs on the mirrored image
	gray_after_mirror: assert property (@(posedge clk) disable iff (!arst_n)
		gray_done |-> mirror_done)
		else $error("gray_done high while mirror_done low");

	mirror_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		mirror_done |=> mirror_done)
		else $error("mirror_done fell");

	gray_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		gray_done |=> gray_done)
		else $error("gray_done fell");

endmodule

`default_nettype wire

// ==== verif/img_proc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module img_proc_tb;
	import img_proc_pkg::*;

	localparam int MIRROR_CYCLES = HALF_ROWS * IMG_DIM * 4;          // Four cycles per pair
	localparam int GRAY_CYCLES   = IMG_DIM * IMG_DIM * 2;            // Two cycles per pixel
	localparam int MIRROR_EDGE   = MIRROR_CYCLES;                    // Edge that sets mirror_done
	localparam int GRAY_EDGE     = MIRROR_CYCLES + 1 + GRAY_CYCLES;  // Gap cycle in between
	localparam int SETTLE        = 16;                               // Idle cycles watched at the end
	localparam int MAX_CYCLES    = ((GRAY_EDGE + SETTLE) / 1000 + 4) * 1000; // About 20 % headroom
	localparam int N_PROBES      = 10;

	typedef struct packed {
		coord_t row;  // Final position checked
		coord_t col;
		pixel_t orig; // Forced at (63-row, col) before reset release
		pixel_t exp;  // Max/min midpoint in G, worked out by hand
	} probe_t;

	localparam probe_t PROBES [N_PROBES] = '{
		'{6'd0,  6'd0,  24'h000000, 24'h000000}, // All zero
		'{6'd63, 6'd63, 24'hFFFFFF, 24'h00FF00}, // All 255
		'{6'd0,  6'd63, 24'hFF0000, 24'h007F00}, // Red only, 255/2 floors
		'{6'd63, 6'd0,  24'h00FF00, 24'h007F00}, // Green only
		'{6'd31, 6'd10, 24'h0000FF, 24'h007F00}, // Blue only, last upper row
		'{6'd32, 6'd10, 24'h030506, 24'h000400}, // 6+3 odd
		'{6'd31, 6'd0,  24'h64C801, 24'h006400}, // 200+1 odd
		'{6'd32, 6'd63, 24'h808081, 24'h008000}, // Sum carries into bit 8
		'{6'd17, 6'd42, 24'hFE01FF, 24'h008000}, // 255+1
		'{6'd45, 6'd5,  24'h102031, 24'h002000}  // 49+16 odd
	};

	logic   clk = 1'b0;
	logic   arst_n;
	pixel_t in_pix;
	coord_t row, col;
	logic   we;
	pixel_t pix;
	logic   mirror_done, gray_done;

	pixel_t mem  [IMG_DIM][IMG_DIM]; // External image memory
	pixel_t orig [IMG_DIM][IMG_DIM]; // Image as it was before processing

	int seed;
	int errors;
	int tests_run, tests_failed;
	int cycles = 0;                       // Rising edges since reset release
	int mir_writes = 0, gray_writes = 0;
	int mirror_edge = -1, gray_edge = -1; // Edge count when each flag was first seen high
	bit flag_dropped = 1'b0;

	always #50 clk = ~clk;

	img_proc_top img_proc_top_i (
		.clk(clk), .arst_n(arst_n), .in_pix(in_pix), .row(row), .col(col),
		.we(we), .pix(pix), .mirror_done(mirror_done), .gray_done(gray_done)
	);

	bind img_proc_top img_proc_props img_proc_props_i (
		.clk(clk), .arst_n(arst_n), .we(we), .mirror_done(mirror_done), .gray_done(gray_done)
	);

	assign in_pix = mem[row][col]; // Combinational read port

	always @(posedge clk) begin
		if (we) mem[row][col] <= pix; // Write strobe takes effect on the edge
	end

	always @(posedge clk) begin
		if (arst_n) cycles <= cycles + 1;
	end

	// Flags and strobes sampled mid cycle, where they are settled
	always @(negedge clk) begin
		if (cycles > 0) begin
			if (we && !mirror_done) mir_writes++;
			if (we && mirror_done) gray_writes++;    // Anything after the mirror pass
			if (mirror_done && mirror_edge < 0) mirror_edge = cycles;
			if (gray_done && gray_edge < 0) gray_edge = cycles;
			if ((mirror_edge >= 0 && !mirror_done) || (gray_edge >= 0 && !gray_done))
				flag_dropped = 1'b1;
		end
		if (cycles >= MAX_CYCLES) begin
			$display("Design timed out: gray_done still low after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic expect_true(input bit ok, input string what);
		assert (ok) else begin
			$display("[ERROR] %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: %0d errors", tests_run, name, errors - errors_before);
		end
	endtask

	// R and B cleared, G holds floor of (max + min) / 2
	function automatic pixel_t gray_of(input pixel_t p);
		int r, g, b, mx, mn;
		r  = int'(p[2*CHAN_W +: CHAN_W]);
		g  = int'(p[CHAN_W +: CHAN_W]);
		b  = int'(p[0 +: CHAN_W]);
		mx = (r > g) ? ((r > b) ? r : b) : ((g > b) ? g : b);
		mn = (r < g) ? ((r < b) ? r : b) : ((g < b) ? g : b);
		return {8'h00, 8'((mx + mn) / 2), 8'h00};
	endfunction

	initial begin
		int     e0;
		int     orow;
		pixel_t v;
		pixel_t got;
		seed         = 15734;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		arst_n       = 1'b0;
		for (int r = 0; r < IMG_DIM; r++) begin
			for (int c = 0; c < IMG_DIM; c++) begin
				v          = pixel_t'($random(seed));
				orig[r][c] = v;
				mem[r][c] <= v;
			end
		end
		for (int p = 0; p < N_PROBES; p++) begin // Edge cases land on the mirrored row
			orow                         = IMG_DIM - 1 - int'(PROBES[p].row);
			orig[orow][PROBES[p].col]    = PROBES[p].orig;
			mem[orow][PROBES[p].col]    <= PROBES[p].orig;
		end

		repeat (10) @(negedge clk);
		e0 = errors;
		expect_true(!we && !mirror_done && !gray_done, "we or a done flag high out of reset");
		report_test("reset state", e0);
		arst_n = 1'b1;

		while (!gray_done) @(negedge clk);
		repeat (SETTLE) @(negedge clk);   // Flags must hold, no late writes

		e0 = errors;
		expect_true(mirror_edge == MIRROR_EDGE, $sformatf("mirror_done after %0d edges, expected %0d",
			mirror_edge, MIRROR_EDGE));
		expect_true(gray_edge == GRAY_EDGE, $sformatf("gray_done after %0d edges, expected %0d",
			gray_edge, GRAY_EDGE));
		expect_true(!flag_dropped, "a done flag fell after it had risen");
		report_test("done timing", e0);

		e0 = errors;
		expect_true(mir_writes == HALF_ROWS * IMG_DIM * 2, $sformatf("%0d mirror writes", mir_writes));
		expect_true(gray_writes == IMG_DIM * IMG_DIM, $sformatf("%0d gray writes", gray_writes));
		report_test("write count", e0);

		e0 = errors;
		for (int p = 0; p < N_PROBES; p++) begin
			got = mem[PROBES[p].row][PROBES[p].col];
			expect_true(got == PROBES[p].exp, $sformatf("probe (%0d,%0d) holds %h, expected %h",
				PROBES[p].row, PROBES[p].col, got, PROBES[p].exp));
		end
		report_test("probe table", e0);

		e0 = errors;
		for (int r = 0; r < IMG_DIM; r++) begin
			for (int c = 0; c < IMG_DIM; c++) begin
				got = mem[r][c];
				expect_true(got == gray_of(orig[IMG_DIM-1-r][c]),
					$sformatf("pixel (%0d,%0d) holds %h", r, c, got));
				expect_true(got[2*CHAN_W +: CHAN_W] == 8'h00 && got[0 +: CHAN_W] == 8'h00,
					$sformatf("pixel (%0d,%0d) has R or B set", r, c));
			end
		end
		report_test("full sweep", e0);

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/img_proc_pkg.sv
hdl/scan_counter.sv
hdl/mirror_engine.sv
hdl/gray_engine.sv
hdl/img_proc_ctrl.sv
hdl/img_proc_top.sv
verif/img_proc_props.sv
verif/img_proc_tb.sv

// ==== Makefile ====
# Verilator flow for the image processing project

VERILATOR ?= verilator
FLAGS     := --timing --assert --timescale 1ns/10ps
TOP       := img_proc_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
